// ==== vlog.f ====
+incdir+source
source/sramul_pkg.sv
source/lane_sram.sv
source/sram_to_sram_mul_core.sv
source/mul_ctrl_regs.sv
source/sramul_top.sv
sim/tb_sramul.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sramul testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_sramul \
    -Mdir obj_dir -f vlog.f > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/Vtb_sramul > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

echo "simulation passed"
exit 0

// ==== sim/tb_sramul.sv ====
`timescale 1ns/1ps

`include "sramul_config.svh"

module tb_sramul;

    localparam int DEPTH      = 2 ** `SRAMUL_ADDR_BITS;
    localparam int WAIT_LIMIT = 2000;
    localparam int PROD_BITS  = 2 * `SRAMUL_DATA_BITS;

    typedef logic [PROD_BITS-1:0] prod_t;

    logic                  clk;
    logic                  reset;
    logic                  cke;
    sramul_pkg::mem_wr_t   mem0_wr;
    sramul_pkg::mem_wr_t   mem1_wr;
    sramul_pkg::mem_rd_t   mem2_rd;
    sramul_pkg::lane_vec_t mem2_rdata;
    sramul_pkg::reg_wr_t   reg_wr;
    logic                  busy;
    logic                  done_flag;
    logic                  done;

    // shadow copies of the three memories
    sramul_pkg::lane_vec_t src0_model [DEPTH];
    sramul_pkg::lane_vec_t src1_model [DEPTH];
    sramul_pkg::lane_vec_t dst_model  [DEPTH];

    logic [31:0] lfsr_state;
    int          mismatch_count;
    int          failure_count;
    int          start_count;
    int          done_count;
    logic        done_seen;

    sramul_top UUT (
        .clk        (clk),
        .reset      (reset),
        .cke        (cke),
        .mem0_wr    (mem0_wr),
        .mem1_wr    (mem1_wr),
        .mem2_rd    (mem2_rd),
        .mem2_rdata (mem2_rdata),
        .reg_wr     (reg_wr),
        .busy       (busy),
        .done_flag  (done_flag),
        .done       (done)
    );

    always #50 clk = ~clk;

    // done can stretch while cke is low, so count rising edges
    always @(negedge clk) begin
        if (reset) begin
            done_count <= 0;
            done_seen  <= 1'b0;
        end else begin
            if (done && !done_seen) begin
                done_count <= done_count + 1;
            end
            done_seen <= done;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic load_sources();
        logic [31:0] r0;
        logic [31:0] r1;
        for (int a = 0; a < DEPTH; a++) begin
            take_bits(32, r0);
            take_bits(32, r1);
            mem0_wr.wen   = 1'b1;
            mem0_wr.waddr = sramul_pkg::addr_t'(a);
            mem0_wr.wdata = r0;
            mem1_wr.wen   = 1'b1;
            mem1_wr.waddr = sramul_pkg::addr_t'(a);
            mem1_wr.wdata = r1;
            src0_model[a] = r0;
            src1_model[a] = r1;
            @(negedge clk);
        end
        mem0_wr.wen = 1'b0;
        mem1_wr.wen = 1'b0;
    endtask

    task automatic write_reg(input logic sel, input sramul_pkg::addr_t value);
        reg_wr.wen   = 1'b1;
        reg_wr.sel   = sel;
        reg_wr.wdata = value;
        @(negedge clk);
        reg_wr.wen = 1'b0;
    endtask

    // lane-wise product, low lane bits kept
    task automatic update_model(input sramul_pkg::addr_t last);
        prod_t full;
        for (int a = 0; a <= int'(last); a++) begin
            for (int i = 0; i < `SRAMUL_UNIT_LEN; i++) begin
                full = prod_t'(src0_model[a][i]) * prod_t'(src1_model[a][i]);
                dst_model[a][i] = full[`SRAMUL_DATA_BITS-1:0];
            end
        end
    endtask

    // poke_start keeps a start request on the register port every cycle
    task automatic wait_idle(input logic random_cke, input logic poke_start);
        logic [31:0] r;
        int          cycles;
        cycles = 0;
        while (busy && cycles < WAIT_LIMIT) begin
            if (random_cke) begin
                take_bits(1, r);
                cke = r[0];
            end
            if (poke_start) begin
                reg_wr.wen   = 1'b1;
                reg_wr.sel   = 1'b0;
                reg_wr.wdata = sramul_pkg::addr_t'(1);
            end
            @(negedge clk);
            cycles++;
        end
        reg_wr.wen = 1'b0;
        cke        = 1'b1;
        assert (!busy) else begin
            $display("timeout at %0t: busy did not fall within %0d cycles", $time, WAIT_LIMIT);
            failure_count++;
        end
    endtask

    task automatic run(input sramul_pkg::addr_t last, input logic random_cke);
        write_reg(1'b1, last);
        write_reg(1'b0, sramul_pkg::addr_t'(1));
        start_count++;
        update_model(last);
        wait_idle(random_cke, 1'b0);
    endtask

    task automatic check_bit(input string what, input logic actual, input logic expected);
        assert (actual === expected) else begin
            $display("mismatch at %0t: %s expected %b got %b", $time, what, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_all();
        for (int a = 0; a < DEPTH; a++) begin
            mem2_rd.ren   = 1'b1;
            mem2_rd.raddr = sramul_pkg::addr_t'(a);
            repeat (2) @(negedge clk);
            assert (mem2_rdata === dst_model[a]) else begin
                $display("mismatch at %0t: addr %0d expected %h got %h",
                         $time, a, dst_model[a], mem2_rdata);
                mismatch_count++;
            end
        end
        mem2_rd.ren = 1'b0;
    endtask

    initial begin
        logic [31:0]       r;
        sramul_pkg::addr_t short_last;
        int                done_before;
        clk            = 1'b0;
        reset          = 1'b1;
        cke            = 1'b1;
        mem0_wr        = '0;
        mem1_wr        = '0;
        mem2_rd        = '0;
        reg_wr         = '0;
        lfsr_state     = 32'h12e2_8a98;
        mismatch_count = 0;
        failure_count  = 0;
        start_count    = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_bit("busy after reset", busy, 1'b0);
        check_bit("done_flag after reset", done_flag, 1'b0);
        check_bit("done after reset", done, 1'b0);

        // full run with cke held high
        load_sources();
        run(sramul_pkg::addr_t'(DEPTH - 1), 1'b0);
        check_all();
        check_bit("busy after run", busy, 1'b0);
        check_bit("done_flag after run", done_flag, 1'b1);

        // full run with random stalls
        load_sources();
        run(sramul_pkg::addr_t'(DEPTH - 1), 1'b1);
        check_all();

        // short run leaves the upper words alone
        take_bits(`SRAMUL_ADDR_BITS, r);
        short_last = sramul_pkg::addr_t'(r % (DEPTH - 1));
        load_sources();
        run(short_last, 1'b0);
        check_all();

        // writes while busy must be dropped, also once stage 0 has drained
        take_bits(`SRAMUL_ADDR_BITS, r);
        short_last = sramul_pkg::addr_t'(r % (DEPTH - 1));
        load_sources();
        done_before = done_count;
        write_reg(1'b1, short_last);
        write_reg(1'b0, sramul_pkg::addr_t'(1));
        start_count++;
        update_model(short_last);
        check_bit("busy during run", busy, 1'b1);
        write_reg(1'b1, sramul_pkg::addr_t'(DEPTH - 1));
        wait_idle(1'b0, 1'b1);
        check_all();
        assert (done_count - done_before == 1) else begin
            $display("mismatch at %0t: done pulses in guarded run expected 1 got %0d",
                     $time, done_count - done_before);
            mismatch_count++;
        end

        assert (done_count == start_count) else begin
            $display("mismatch at %0t: done pulses expected %0d got %0d",
                     $time, start_count, done_count);
            mismatch_count++;
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count + failure_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== source/sramul_top.sv ====
`timescale 1ns/1ps

module sramul_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cke,
    input  sramul_pkg::mem_wr_t   mem0_wr,
    input  sramul_pkg::mem_wr_t   mem1_wr,
    input  sramul_pkg::mem_rd_t   mem2_rd,
    output sramul_pkg::lane_vec_t mem2_rdata,
    input  sramul_pkg::reg_wr_t   reg_wr,
    output logic                  busy,
    output logic                  done_flag,
    output logic                  done
);

    // core side of the source memories
    sramul_pkg::mem_rd_t   src_rd;
    sramul_pkg::lane_vec_t src0_rdata;
    sramul_pkg::lane_vec_t src1_rdata;

    // core side of the destination memory
    sramul_pkg::mem_wr_t   dst_wr;

    logic                  start;
    sramul_pkg::addr_t     last_addr;

    lane_sram src0_mem (
        .clk   (clk),
        .cke   (cke),
        .wr    (mem0_wr),
        .rd    (src_rd),
        .rdata (src0_rdata)
    );

    lane_sram src1_mem (
        .clk   (clk),
        .cke   (cke),
        .wr    (mem1_wr),
        .rd    (src_rd),
        .rdata (src1_rdata)
    );

    // host reads results through this one
    lane_sram dst_mem (
        .clk   (clk),
        .cke   (cke),
        .wr    (dst_wr),
        .rd    (mem2_rd),
        .rdata (mem2_rdata)
    );

    sram_to_sram_mul_core u_core (
        .clk        (clk),
        .reset      (reset),
        .cke        (cke),
        .start      (start),
        .last_addr  (last_addr),
        .done       (done),
        .src_rd     (src_rd),
        .src0_rdata (src0_rdata),
        .src1_rdata (src1_rdata),
        .dst_wr     (dst_wr)
    );

    mul_ctrl_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .cke       (cke),
        .reg_wr    (reg_wr),
        .done      (done),
        .start     (start),
        .last_addr (last_addr),
        .busy      (busy),
        .done_flag (done_flag)
    );

endmodule

// ==== source/mul_ctrl_regs.sv ====
`timescale 1ns/1ps

module mul_ctrl_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                cke,
    input  sramul_pkg::reg_wr_t reg_wr,
    input  logic                done,
    output logic                start,
    output sramul_pkg::addr_t   last_addr,
    output logic                busy,
    output logic                done_flag
);

    logic start_accept;
    logic last_addr_load;
    logic start_pending;

    // register writes are dropped while a run is in progress
    assign start_accept   = reg_wr.wen & ~reg_wr.sel & reg_wr.wdata[0] & ~busy;
    assign last_addr_load = reg_wr.wen & reg_wr.sel & ~busy;

    // pending start is held until the core sees a cke edge
    always_ff @(posedge clk) begin
        if (reset) begin
            start_pending <= 1'b0;
        end else if (start_accept) begin
            start_pending <= 1'b1;
        end else if (cke) begin
            start_pending <= 1'b0;
        end
    end

    assign start = start_pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_addr <= '0;
        end else if (last_addr_load) begin
            last_addr <= reg_wr.wdata;
        end
    end

    // busy and sticky done status
    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            done_flag <= 1'b0;
        end else if (start_accept) begin
            busy      <= 1'b1;
            done_flag <= 1'b0;
        end else if (done) begin
            busy      <= 1'b0;
            done_flag <= 1'b1;
        end
    end

endmodule

// ==== source/sram_to_sram_mul_core.sv ====
`timescale 1ns/1ps

`include "sramul_config.svh"

module sram_to_sram_mul_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cke,
    input  logic                  start,
    input  sramul_pkg::addr_t     last_addr,
    output logic                  done,
    output sramul_pkg::mem_rd_t   src_rd,
    input  sramul_pkg::lane_vec_t src0_rdata,
    input  sramul_pkg::lane_vec_t src1_rdata,
    output sramul_pkg::mem_wr_t   dst_wr
);

    sramul_pkg::addr_t     st0_addr;
    logic                  st0_valid;

    sramul_pkg::addr_t     st1_addr;
    logic                  st1_valid;

    sramul_pkg::addr_t     st2_addr;
    logic                  st2_valid;

    sramul_pkg::addr_t     st3_addr;
    logic                  st3_valid;

    sramul_pkg::addr_t     st4_addr;
    sramul_pkg::lane_vec_t st4_data0;
    sramul_pkg::lane_vec_t st4_data1;
    logic                  st4_valid;

    sramul_pkg::addr_t     st5_addr;
    sramul_pkg::lane_vec_t st5_data;
    logic                  st5_valid;

    // valid bits and done pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            st0_valid <= 1'b0;
            st1_valid <= 1'b0;
            st2_valid <= 1'b0;
            st3_valid <= 1'b0;
            st4_valid <= 1'b0;
            st5_valid <= 1'b0;
            done      <= 1'b0;
        end else if (cke) begin
            // stage 0 keeps running until the last address has been issued
            if (st0_valid) begin
                st0_valid <= (st0_addr != last_addr);
            end else begin
                st0_valid <= start;
            end
            st1_valid <= st0_valid;
            st2_valid <= st1_valid;
            st3_valid <= st2_valid;
            st4_valid <= st3_valid;
            st5_valid <= st4_valid;
            // tail of the stream leaves stage 5
            done      <= st5_valid & ~st4_valid;
        end
    end

    // address and data path
    always_ff @(posedge clk) begin
        if (cke) begin
            if (st0_valid) begin
                st0_addr <= st0_addr + 1'b1;
            end else begin
                st0_addr <= '0;
            end
            st1_addr  <= st0_addr;
            st2_addr  <= st1_addr;
            st3_addr  <= st2_addr;
            st4_addr  <= st3_addr;
            st4_data0 <= src0_rdata;
            st4_data1 <= src1_rdata;
            st5_addr  <= st4_addr;
            // products keep only the low lane bits
            for (int i = 0; i < `SRAMUL_UNIT_LEN; i++) begin
                st5_data[i] <= st4_data0[i] * st4_data1[i];
            end
        end
    end

    // stage 1 issues the read to both sources
    always_comb begin
        src_rd.ren   = st1_valid;
        src_rd.raddr = st1_addr;
    end

    always_comb begin
        dst_wr.wen   = st5_valid;
        dst_wr.waddr = st5_addr;
        dst_wr.wdata = st5_data;
    end

endmodule

// ==== source/lane_sram.sv ====
`timescale 1ns/1ps

`include "sramul_config.svh"

module lane_sram (
    input  logic                  clk,
    input  logic                  cke,
    input  sramul_pkg::mem_wr_t   wr,
    input  sramul_pkg::mem_rd_t   rd,
    output sramul_pkg::lane_vec_t rdata
);

    localparam int DEPTH = 2 ** `SRAMUL_ADDR_BITS;

    sramul_pkg::lane_vec_t mem [DEPTH];

    logic                  ren_q;
    sramul_pkg::addr_t     raddr_q;

    // write port runs regardless of cke
    always_ff @(posedge clk) begin
        if (wr.wen) begin
            mem[wr.waddr] <= wr.wdata;
        end
    end

    // first read stage latches the request
    always_ff @(posedge clk) begin
        if (cke) begin
            ren_q   <= rd.ren;
            raddr_q <= rd.raddr;
        end
    end

    // second read stage, output holds while stalled or idle
    always_ff @(posedge clk) begin
        if (cke && ren_q) begin
            rdata <= mem[raddr_q];
        end
    end

endmodule

// ==== source/sramul_pkg.sv ====
package sramul_pkg;

    `include "sramul_config.svh"

    typedef logic [`SRAMUL_ADDR_BITS-1:0] addr_t;

    typedef logic [`SRAMUL_DATA_BITS-1:0] data_t;

    // one memory word, lane 0 in the low bits
    typedef data_t [`SRAMUL_UNIT_LEN-1:0] lane_vec_t;

    // read request to a lane memory
    typedef struct packed {
        logic  ren;
        addr_t raddr;
    } mem_rd_t;

    // write request to a lane memory
    typedef struct packed {
        logic      wen;
        addr_t     waddr;
        lane_vec_t wdata;
    } mem_wr_t;

    // host register write, sel 0 is control and sel 1 is last address
    typedef struct packed {
        logic                         wen;
        logic                         sel;
        logic [`SRAMUL_ADDR_BITS-1:0] wdata;
    } reg_wr_t;

endpackage

// ==== source/sramul_config.svh ====
`ifndef SRAMUL_CONFIG_SVH
`define SRAMUL_CONFIG_SVH

// word address width, 16 words per memory
`define SRAMUL_ADDR_BITS 4

// width of one lane
`define SRAMUL_DATA_BITS 8

// lanes per memory word
`define SRAMUL_UNIT_LEN 4

`endif
